// File: dfp_defines.svh
/*
 * decimal floating point rounding coprocessor
 * format sizes, rounding mode codes, AXI4-Lite
 * register map and response codes
 */
`ifndef DFP_DEFINES_SVH
`define DFP_DEFINES_SVH

// kept significand digits and exponent width
`define DFP_DIGITS      7
`define DFP_EXP_W       8
// exponent code reserved for infinity and NaN
`define DFP_EXP_RSV     8'hFF

// rounding modes, any other code rounds down
`define RM_CEILING      3'd0
`define RM_FLOOR        3'd1
`define RM_HALF_UP      3'd2
`define RM_HALF_EVEN    3'd3
`define RM_DOWN         3'd4

// register map, 0x10 is one past the last register
`define DFP_ADDR_W      5
`define REG_SIG         5'h00
`define REG_CTRL        5'h04
`define REG_RES_SIG     5'h08
`define REG_RES_HI      5'h0C

// AXI response codes
`define AXI_OKAY        2'b00
`define AXI_SLVERR      2'b10

`endif

// File: dfpPkg.sv
/*
 * dfpPkg
 * types shared by the decimal rounding coprocessor:
 * BCD significands, exponent, rounding mode, packed
 * stored result and the AXI write FSM states
 */
`default_nettype none

`include "dfp_defines.svh"

package dfpPkg;

	// kept BCD significand, one nibble per digit
	typedef logic [`DFP_DIGITS*4-1:0] digits_t;

	// unrounded significand
	// kept digits on top, guard digit in the lowest nibble
	typedef logic [(`DFP_DIGITS+1)*4-1:0] digitsIn_t;

	// biased exponent
	typedef logic [`DFP_EXP_W-1:0] exp_t;

	// rounding mode code, see RM_* macros
	typedef logic [2:0] roundMode_t;

	// stored result, msb first: sign, exponent, digits
	// inf  -> reserved exponent, all digits zero
	// qNaN -> reserved exponent, leading digit F
	// sNaN -> reserved exponent, leading digit E
	typedef logic [`DFP_EXP_W+`DFP_DIGITS*4:0] dfpPacked_t;

	// AXI write side
	typedef enum logic {
		stIdle,
		stRespond
	} regState_t;

endpackage

`default_nettype wire

// File: bcdAddN.sv
/*
 * bcdAddN
 * N-digit BCD ripple adder, carry in at the lowest digit
 * and decimal carry out of the top digit
 */
`timescale 1ns/1ps
`default_nettype none

module bcdAddN #(
	parameter int N = 4
) (
	input  logic         ci,
	input  logic [N*4-1:0] a,
	input  logic [N*4-1:0] b,
	output logic [N*4-1:0] o,
	output logic         co
);

	// carry between digits, c[0] is the carry in
	logic [N:0] c;

	assign c[0] = ci;

	for (genvar i = 0; i < N; i++) begin : gDigit
		// binary digit sum, max 9+9+1 = 19
		logic [4:0] raw;
		// sum with the decimal correction applied
		logic [4:0] adj;

		assign raw = {1'b0, a[i*4 +: 4]} + {1'b0, b[i*4 +: 4]} + {4'b0, c[i]};
		assign adj = raw + 5'd6;

		// anything past 9 wraps by adding 6 and carries on
		assign c[i+1] = (raw > 5'd9);
		assign o[i*4 +: 4] = c[i+1] ? adj[3:0] : raw[3:0];
	end

	assign co = c[N];

endmodule

`default_nettype wire

// File: dfpPack.sv
/*
 * dfpPack
 * encodes rounded fields and class flags into the stored
 * format, specials go to the reserved exponent
 */
`timescale 1ns/1ps
`default_nettype none

`include "dfp_defines.svh"

module dfpPack
	import dfpPkg::*;
(
	input  logic       sign,
	input  logic       nan,
	input  logic       qnan,
	input  logic       snan,
	input  logic       infinity,
	input  exp_t       exp,
	input  digits_t    sig,
	output dfpPacked_t packedOut
);

	exp_t    pkExp;
	digits_t pkSig;

	always_comb begin
		// finite values go straight through
		pkExp = exp;
		pkSig = sig;
		if (nan) begin
			// NaN wins over infinity
			pkExp = `DFP_EXP_RSV;
			pkSig = '0;
			// quiet unless only the signalling flag is set
			if (qnan || !snan)
				pkSig[`DFP_DIGITS*4-1 -: 4] = 4'hF;
			else
				pkSig[`DFP_DIGITS*4-1 -: 4] = 4'hE;
		end else if (infinity) begin
			pkExp = `DFP_EXP_RSV;
			pkSig = '0;
		end
	end

	// sign is kept for every class
	assign packedOut = {sign, pkExp, pkSig};

endmodule

`default_nettype wire

// File: dfpRound.sv
/*
 * dfpRound
 * four-stage decimal rounding pipeline
 * 1: round bit from guard digit and mode
 * 2: BCD increment, exponent bump on carry
 * 3: significand select, overflow to infinity
 * 4: pack and register the result
 */
`timescale 1ns/1ps
`default_nettype none

`include "dfp_defines.svh"

module dfpRound
	import dfpPkg::*;
(
	input  logic       clk,
	input  logic       arstN,
	input  logic       inValid,
	input  digitsIn_t  sig,
	input  exp_t       exp,
	input  logic       sign,
	input  logic       nan,
	input  logic       qnan,
	input  logic       snan,
	input  logic       infinity,
	input  roundMode_t rm,
	output logic       outValid,
	output dfpPacked_t result
);

	// valid chain, outValid is the last link
	logic v1, v2, v3;

	// stage 1 registers
	digits_t sig1;
	exp_t    exp1;
	logic    rnd1, sign1, nan1, qnan1, snan1, inf1;

	// stage 2 registers
	digits_t sig2, sum2;
	exp_t    expInc2;
	logic    carry2, den2, rnd2, sign2, nan2, qnan2, snan2, inf2;

	// stage 3 registers
	digits_t sig3;
	exp_t    exp3;
	logic    sign3, nan3, qnan3, snan3, inf3;

	// --------------------
	// stage 1, round decision

	logic [3:0] guard;
	logic [3:0] lastKept;
	logic       rndNext;

	assign guard    = sig[3:0];
	assign lastKept = sig[7:4];

	always_comb begin
		// specials are never rounded
		if (nan || infinity) begin
			rndNext = 1'b0;
		end else begin
			case (rm)
				// away from zero only for positive values
				`RM_CEILING:   rndNext = !sign && (guard != 4'd0);
				`RM_FLOOR:     rndNext = sign && (guard != 4'd0);
				`RM_HALF_UP:   rndNext = (guard >= 4'd5);
				// ties go to the even last digit
				`RM_HALF_EVEN: rndNext = (guard > 4'd5) || (guard == 4'd5 && lastKept[0]);
				default:       rndNext = 1'b0;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		// guard digit dropped here
		sig1  <= sig[(`DFP_DIGITS+1)*4-1:4];
		exp1  <= exp;
		rnd1  <= rndNext;
		sign1 <= sign;
		nan1  <= nan;
		qnan1 <= qnan;
		snan1 <= snan;
		inf1  <= infinity;
	end

	// --------------------
	// stage 2, increment

	digits_t sum1;
	logic    carry1;

	// round bit enters as the carry in
	bcdAddN #(
		.N(`DFP_DIGITS)
	) bcdAdd_inst (
		.ci(rnd1),
		.a (sig1),
		.b ('0),
		.o (sum1),
		.co(carry1)
	);

	always_ff @(posedge clk) begin
		sig2    <= sig1;
		sum2    <= sum1;
		carry2  <= carry1;
		// a new leading digit bumps the exponent
		expInc2 <= exp1 + {{(`DFP_EXP_W-1){1'b0}}, carry1};
		// denormal marker
		den2    <= (exp1 == '0);
		rnd2    <= rnd1;
		sign2   <= sign1;
		nan2    <= nan1;
		qnan2   <= qnan1;
		snan2   <= snan1;
		inf2    <= inf1;
	end

	// --------------------
	// stage 3, significand select

	logic    ovf2;
	digits_t sigSel;

	// rounding up into the reserved exponent means infinity
	assign ovf2 = rnd2 && (expInc2 == `DFP_EXP_RSV);

	always_comb begin
		if (!rnd2)
			sigSel = sig2;
		else if (ovf2)
			sigSel = '0;
		else if (!carry2 || den2)
			// denormal carry just becomes normal, no shift
			sigSel = sum2;
		else
			// 9..9 + 1 on a normal number, new leading 1
			sigSel = {4'h1, sum2[`DFP_DIGITS*4-1:4]};
	end

	always_ff @(posedge clk) begin
		sig3  <= sigSel;
		exp3  <= expInc2;
		sign3 <= sign2;
		nan3  <= nan2;
		qnan3 <= qnan2;
		snan3 <= snan2;
		inf3  <= inf2 | ovf2;
	end

	// --------------------
	// stage 4, pack

	dfpPacked_t packed3;

	dfpPack dfpPack_inst (
		.sign     (sign3),
		.nan      (nan3),
		.qnan     (qnan3),
		.snan     (snan3),
		.infinity (inf3),
		.exp      (exp3),
		.sig      (sig3),
		.packedOut(packed3)
	);

	always_ff @(posedge clk) begin
		result <= packed3;
	end

	// valid travels with the data, no stalls
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			v1       <= 1'b0;
			v2       <= 1'b0;
			v3       <= 1'b0;
			outValid <= 1'b0;
		end else begin
			v1       <= inValid;
			v2       <= v1;
			v3       <= v2;
			outValid <= v3;
		end
	end

	// --------------------
	// checks

	// every accepted item leaves exactly four cycles later
	aLatency: assert property (@(posedge clk) disable iff (!arstN)
		inValid |-> ##4 outValid);
	aNoSpurious: assert property (@(posedge clk) disable iff (!arstN)
		outValid |-> $past(inValid, 4));

	// host must not flag a value as both NaN and infinity
	aClass: assert property (@(posedge clk) disable iff (!arstN)
		v1 |-> !(nan1 && inf1));

endmodule

`default_nettype wire

// File: dfpAxiRegs.sv
/*
 * dfpAxiRegs
 * AXI4-Lite slave for the rounding coprocessor
 * operand and control registers, launch pulse,
 * result capture and done flag
 */
`timescale 1ns/1ps
`default_nettype none

`include "dfp_defines.svh"

module dfpAxiRegs
	import dfpPkg::*;
(
	input  logic                   clk,
	input  logic                   arstN,
	// write address
	input  logic [`DFP_ADDR_W-1:0] awaddr,
	input  logic                   awvalid,
	output logic                   awready,
	// write data, wstrb ignored since every write is a full word
	input  logic [31:0]            wdata,
	input  logic [3:0]             wstrb,
	input  logic                   wvalid,
	output logic                   wready,
	// write response
	output logic [1:0]             bresp,
	output logic                   bvalid,
	input  logic                   bready,
	// read address
	input  logic [`DFP_ADDR_W-1:0] araddr,
	input  logic                   arvalid,
	output logic                   arready,
	// read data
	output logic [31:0]            rdata,
	output logic [1:0]             rresp,
	output logic                   rvalid,
	input  logic                   rready,
	// to the rounder
	output logic                   inValid,
	output digitsIn_t              sig,
	output exp_t                   exp,
	output logic                   sign,
	output logic                   nan,
	output logic                   qnan,
	output logic                   snan,
	output logic                   infinity,
	output roundMode_t             rm,
	// from the rounder
	input  logic                   outValid,
	input  dfpPacked_t             result
);

	regState_t  wrState;
	digitsIn_t  sigReg;
	logic [15:0] ctrlReg;
	dfpPacked_t resReg;
	logic       done;
	logic       wrFire, ctrlWr, rdFire;
	logic [31:0] rdMux;

	// only the four word offsets exist
	function automatic logic addrOk(input logic [`DFP_ADDR_W-1:0] a);
		return a inside {`REG_SIG, `REG_CTRL, `REG_RES_SIG, `REG_RES_HI};
	endfunction

	assign wrFire = awvalid && awready && wvalid && wready;
	assign ctrlWr = wrFire && (awaddr == `REG_CTRL);
	assign rdFire = arvalid && arready;

	// control word fields
	assign sig      = sigReg;
	assign exp      = ctrlReg[7:0];
	assign sign     = ctrlReg[8];
	assign nan      = ctrlReg[9];
	assign qnan     = ctrlReg[10];
	assign snan     = ctrlReg[11];
	assign infinity = ctrlReg[12];
	assign rm       = ctrlReg[15:13];

	// --------------------
	// write side

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			wrState <= stIdle;
			awready <= 1'b0;
			wready  <= 1'b0;
			bvalid  <= 1'b0;
			bresp   <= `AXI_OKAY;
			inValid <= 1'b0;
			sigReg  <= '0;
			ctrlReg <= '0;
		end else begin
			// launch is a single-cycle pulse
			inValid <= 1'b0;
			case (wrState)
				stIdle: begin
					if (wrFire) begin
						awready <= 1'b0;
						wready  <= 1'b0;
						bvalid  <= 1'b1;
						bresp   <= addrOk(awaddr) ? `AXI_OKAY : `AXI_SLVERR;
						wrState <= stRespond;
						if (awaddr == `REG_SIG)
							sigReg <= wdata;
						if (ctrlWr) begin
							ctrlReg <= wdata[15:0];
							inValid <= 1'b1;
						end
					end else if (awvalid && wvalid) begin
						// both channels present, accept them together
						awready <= 1'b1;
						wready  <= 1'b1;
					end
				end
				stRespond: begin
					if (bready) begin
						bvalid  <= 1'b0;
						wrState <= stIdle;
					end
				end
				default: wrState <= stIdle;
			endcase
		end
	end

	// --------------------
	// result capture

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			resReg <= '0;
			done   <= 1'b0;
		end else begin
			if (outValid) begin
				resReg <= result;
				done   <= 1'b1;
			end
			// a new launch clears done
			if (ctrlWr)
				done <= 1'b0;
		end
	end

	// --------------------
	// read side

	always_comb begin
		case (araddr)
			`REG_SIG:     rdMux = sigReg;
			`REG_CTRL:    rdMux = {16'h0, ctrlReg};
			`REG_RES_SIG: rdMux = 32'(digits_t'(resReg));
			// done on top, sign and exponent in 8:0
			`REG_RES_HI:  rdMux = {done, 31'(resReg >> (`DFP_DIGITS*4))};
			default:      rdMux = '0;
		endcase
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			arready <= 1'b0;
			rvalid  <= 1'b0;
			rdata   <= '0;
			rresp   <= `AXI_OKAY;
		end else if (rdFire) begin
			arready <= 1'b0;
			rvalid  <= 1'b1;
			rdata   <= rdMux;
			rresp   <= addrOk(araddr) ? `AXI_OKAY : `AXI_SLVERR;
		end else if (rvalid) begin
			// rdata holds until the master takes it
			if (rready)
				rvalid <= 1'b0;
		end else if (arvalid) begin
			arready <= 1'b1;
		end
	end

	// response stays up until the master takes it
	aBHold: assert property (@(posedge clk) disable iff (!arstN)
		bvalid && !bready |=> bvalid);

endmodule

`default_nettype wire

// File: dfpRoundTop.sv
/*
 * dfpRoundTop
 * decimal rounding coprocessor, AXI4-Lite slave
 * feeding the pipelined rounding unit
 */
`timescale 1ns/1ps
`default_nettype none

`include "dfp_defines.svh"

module dfpRoundTop
	import dfpPkg::*;
(
	input  logic                   clk,
	input  logic                   arstN,
	input  logic [`DFP_ADDR_W-1:0] awaddr,
	input  logic                   awvalid,
	output logic                   awready,
	input  logic [31:0]            wdata,
	input  logic [3:0]             wstrb,
	input  logic                   wvalid,
	output logic                   wready,
	output logic [1:0]             bresp,
	output logic                   bvalid,
	input  logic                   bready,
	input  logic [`DFP_ADDR_W-1:0] araddr,
	input  logic                   arvalid,
	output logic                   arready,
	output logic [31:0]            rdata,
	output logic [1:0]             rresp,
	output logic                   rvalid,
	input  logic                   rready
);

	// operand side
	logic       inValid, sign, nan, qnan, snan, infinity;
	digitsIn_t  sig;
	exp_t       exp;
	roundMode_t rm;
	// result side
	logic       outValid;
	dfpPacked_t result;

	dfpAxiRegs dfpAxiRegs_inst (
		.clk     (clk),
		.arstN   (arstN),
		.awaddr  (awaddr),
		.awvalid (awvalid),
		.awready (awready),
		.wdata   (wdata),
		.wstrb   (wstrb),
		.wvalid  (wvalid),
		.wready  (wready),
		.bresp   (bresp),
		.bvalid  (bvalid),
		.bready  (bready),
		.araddr  (araddr),
		.arvalid (arvalid),
		.arready (arready),
		.rdata   (rdata),
		.rresp   (rresp),
		.rvalid  (rvalid),
		.rready  (rready),
		.inValid (inValid),
		.sig     (sig),
		.exp     (exp),
		.sign    (sign),
		.nan     (nan),
		.qnan    (qnan),
		.snan    (snan),
		.infinity(infinity),
		.rm      (rm),
		.outValid(outValid),
		.result  (result)
	);

	dfpRound dfpRound_inst (
		.clk     (clk),
		.arstN   (arstN),
		.inValid (inValid),
		.sig     (sig),
		.exp     (exp),
		.sign    (sign),
		.nan     (nan),
		.qnan    (qnan),
		.snan    (snan),
		.infinity(infinity),
		.rm      (rm),
		.outValid(outValid),
		.result  (result)
	);

endmodule

`default_nettype wire

// File: tbDfpRound.sv
/*
 * tbDfpRound
 * testbench for the decimal rounding coprocessor
 * drives operands over AXI4-Lite, polls done and
 * checks packed results against a reference model
 */
`timescale 1ns/1ps
`default_nettype none

`include "dfp_defines.svh"

module tbDfpRound
	import dfpPkg::*;
();

	localparam int TIMEOUT_CYCLES = 200 * 40;

	logic                   clk, arstN;
	logic [`DFP_ADDR_W-1:0] awaddr, araddr;
	logic                   awvalid, awready, wvalid, wready, bvalid, bready;
	logic                   arvalid, arready, rvalid, rready;
	logic [31:0]            wdata, rdata;
	logic [3:0]             wstrb;
	logic [1:0]             bresp, rresp;

	logic [31:0] rngState;
	int          cycleCount, pushedCount, checkedCount;

	// pending checks, kind 0 packed result, 1 response, 2 flag
	int         kindQ[$];
	string      nameQ[$];
	dfpPacked_t expQ[$];
	dfpPacked_t actQ[$];

	dfpRoundTop dfpRoundTop_inst (
		.clk(clk), .arstN(arstN),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// --------------------
	// helpers

	task automatic reportFail(input string msg);
		$display("%s", msg);
		$display("FAIL: see errors above");
		$fatal(1, "stopped at first error");
	endtask

	// xorshift32
	function automatic logic [31:0] nextRandom();
		rngState = rngState ^ (rngState << 13);
		rngState = rngState ^ (rngState >> 17);
		rngState = rngState ^ (rngState << 5);
		return rngState;
	endfunction

	// control word: mode 15:13, inf 12, snan 11, qnan 10, nan 9, sign 8, exp 7:0
	function automatic logic [15:0] makeCtrl(input exp_t e, input logic sg, input logic n,
			input logic q, input logic sn, input logic inf, input roundMode_t m);
		return {m, inf, sn, q, n, sg, e};
	endfunction

	// expected stored value, worked out in decimal integers
	function automatic dfpPacked_t roundRef(input digitsIn_t s, input logic [15:0] ctrl);
		int unsigned kept;
		int unsigned g;
		int unsigned e;
		int          k;
		logic        sg;
		logic        up;
		roundMode_t  m;
		digits_t     outSig;
		sg = ctrl[8];
		m  = ctrl[15:13];
		e  = ctrl[7:0];
		g  = s[3:0];
		// specials pass without rounding
		if (ctrl[9])
			return {sg, 8'hFF, (ctrl[11] && !ctrl[10]) ? 4'hE : 4'hF, 24'h0};
		if (ctrl[12])
			return {sg, 8'hFF, 28'h0};
		kept = 0;
		for (k = `DFP_DIGITS; k >= 1; k--)
			kept = kept * 10 + s[k*4 +: 4];
		case (m)
			`RM_CEILING:   up = !sg && (g != 0);
			`RM_FLOOR:     up = sg && (g != 0);
			`RM_HALF_UP:   up = (g >= 5);
			`RM_HALF_EVEN: up = (g > 5) || (g == 5 && (kept % 2) == 1);
			default:       up = 1'b0;
		endcase
		if (up)
			kept++;
		// ten million no longer fits in seven digits
		if (kept == 10_000_000) begin
			if (e == 0) begin
				kept = 0;
				e    = 1;
			end else begin
				kept = 1_000_000;
				e++;
			end
		end
		if (up && e == 255)
			return {sg, 8'hFF, 28'h0};
		for (k = 0; k < `DFP_DIGITS; k++) begin
			outSig[k*4 +: 4] = kept % 10;
			kept = kept / 10;
		end
		return {sg, e[7:0], outSig};
	endfunction

	task automatic enqueue(input int kind, input string name, input dfpPacked_t e,
			input dfpPacked_t a);
		kindQ.push_back(kind);
		nameQ.push_back(name);
		expQ.push_back(e);
		actQ.push_back(a);
		pushedCount++;
	endtask

	// --------------------
	// compare tasks

	task automatic checkPacked(input string name, input dfpPacked_t e, input dfpPacked_t a);
		if (a !== e)
			reportFail($sformatf("FAIL %s: expected %h actual %h", name, e, a));
	endtask

	task automatic checkResp(input string name, input logic [1:0] e, input logic [1:0] a);
		if (a !== e)
			reportFail($sformatf("FAIL %s: expected resp %b actual %b", name, e, a));
	endtask

	task automatic checkFlag(input string name, input logic e, input logic a);
		if (a !== e)
			reportFail($sformatf("FAIL %s: expected flag %b actual %b", name, e, a));
	endtask

	initial begin : compareProc
		int         kind;
		string      name;
		dfpPacked_t e;
		dfpPacked_t a;
		forever begin
			wait (pushedCount > checkedCount);
			kind = kindQ.pop_front();
			name = nameQ.pop_front();
			e    = expQ.pop_front();
			a    = actQ.pop_front();
			case (kind)
				0:       checkPacked(name, e, a);
				1:       checkResp(name, e[1:0], a[1:0]);
				default: checkFlag(name, e[0], a[0]);
			endcase
			checkedCount++;
		end
	end

	// --------------------
	// AXI4-Lite master

	task automatic writeReg(input logic [`DFP_ADDR_W-1:0] addr, input logic [31:0] data,
			output logic [1:0] resp);
		@(negedge clk);
		awaddr  = addr;
		wdata   = data;
		awvalid = 1'b1;
		wvalid  = 1'b1;
		bready  = 1'b1;
		// ready seen here means the next rising edge transfers
		do @(negedge clk); while (!(awready && wready));
		@(negedge clk);
		awvalid = 1'b0;
		wvalid  = 1'b0;
		while (!bvalid)
			@(negedge clk);
		resp = bresp;
		@(negedge clk);
	endtask

	// hold > 0 keeps rready low that many cycles once rvalid is up
	task automatic readReg(input logic [`DFP_ADDR_W-1:0] addr, input int hold,
			output logic [31:0] data, output logic [1:0] resp);
		logic [31:0] first;
		int          i;
		@(negedge clk);
		araddr  = addr;
		arvalid = 1'b1;
		rready  = (hold == 0);
		do @(negedge clk); while (!arready);
		@(negedge clk);
		arvalid = 1'b0;
		while (!rvalid)
			@(negedge clk);
		first = rdata;
		for (i = 0; i < hold; i++) begin
			@(negedge clk);
			if (!rvalid || rdata !== first)
				reportFail("read data or rvalid changed while rready was held low");
		end
		data   = rdata;
		resp   = rresp;
		rready = 1'b1;
		@(negedge clk);
		rready = 1'b0;
	endtask

	// launch one operation and queue its checks
	task automatic runOp(input string name, input digitsIn_t s, input logic [15:0] ctrl,
			input dfpPacked_t expected, input int hold);
		logic [31:0] hi;
		logic [31:0] lo;
		logic [1:0]  r;
		writeReg(`REG_SIG, s, r);
		enqueue(1, {name, " sig write"}, `AXI_OKAY, r);
		writeReg(`REG_CTRL, {16'h0, ctrl}, r);
		enqueue(1, {name, " ctrl write"}, `AXI_OKAY, r);
		hi = '0;
		while (!hi[31])
			readReg(`REG_RES_HI, 0, hi, r);
		readReg(`REG_RES_SIG, hold, lo, r);
		enqueue(1, {name, " result read"}, `AXI_OKAY, r);
		enqueue(0, name, expected, {hi[8:0], lo[27:0]});
	endtask

	// --------------------
	// timeout

	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= TIMEOUT_CYCLES)
			reportFail($sformatf("timeout, run still busy after %0d cycles", cycleCount));
	end

	// --------------------
	// tests

	initial begin : mainProc
		logic [31:0] d;
		logic [1:0]  r;
		digitsIn_t   s;
		logic [15:0] ctrl;
		int          i;
		int          k;
		{awaddr, awvalid, wdata, wvalid, bready} = '0;
		{araddr, arvalid, rready} = '0;
		wstrb        = 4'hF;
		arstN        = 1'b0;
		rngState     = 32'hb902;
		cycleCount   = 0;
		pushedCount  = 0;
		checkedCount = 0;
		repeat (3) @(negedge clk);
		arstN = 1'b1;

		// reset state and bad address
		readReg(`REG_RES_HI, 0, d, r);
		enqueue(2, "done after reset", 1'b0, d[31]);
		enqueue(1, "res hi read resp", `AXI_OKAY, r);
		readReg(5'h10, 0, d, r);
		enqueue(1, "bad read resp", `AXI_SLVERR, r);
		writeReg(5'h10, 32'h0, r);
		enqueue(1, "bad write resp", `AXI_SLVERR, r);

		// random finite operands, mode cycles, sign flips every five
		for (i = 0; i < 40; i++) begin
			s = '0;
			for (k = 0; k < `DFP_DIGITS; k++)
				s = {s[27:4], 4'(nextRandom() % 10), 4'h0};
			s[3:0] = 4'(nextRandom() % 10);
			if (i % 4 == 0) begin
				// tie, last kept digit even or odd
				s[3:0] = 4'd5;
				s[7:4] = 4'((nextRandom() % 5) * 2 + ((i % 8) == 4));
			end
			ctrl = makeCtrl(exp_t'(1 + nextRandom() % 253), (i / 5) % 2, 0, 0, 0, 0,
				roundMode_t'(i % 5));
			runOp($sformatf("random %0d", i), s, ctrl, roundRef(s, ctrl), 0);
		end

		// carry out of all nines
		s = {28'h9999999, 4'h7};
		runOp("carry normal", s, makeCtrl(8'h40, 0, 0, 0, 0, 0, `RM_HALF_UP),
			{1'b0, 8'h41, 28'h1000000}, 0);
		runOp("carry denormal", s, makeCtrl(8'h00, 0, 0, 0, 0, 0, `RM_HALF_UP),
			{1'b0, 8'h01, 28'h0000000}, 0);

		// overflow into the reserved exponent
		s = {28'h9999999, 4'h9};
		runOp("overflow", s, makeCtrl(8'hFE, 0, 0, 0, 0, 0, `RM_HALF_UP),
			{1'b0, 8'hFF, 28'h0}, 0);
		runOp("no overflow down", s, makeCtrl(8'hFE, 0, 0, 0, 0, 0, `RM_DOWN),
			{1'b0, 8'hFE, 28'h9999999}, 0);

		// specials in every mode, k 0 qnan, 1 snan, 2 inf
		for (i = 0; i < 5; i++) begin
			for (k = 0; k < 3; k++) begin
				s = {4'(nextRandom() % 10), 24'h123456, 4'(1 + nextRandom() % 9)};
				ctrl = makeCtrl(8'h10, i % 2, k != 2, k == 0, k == 1, k == 2,
					roundMode_t'(i));
				runOp($sformatf("special %0d mode %0d", k, i), s, ctrl, roundRef(s, ctrl), 0);
			end
		end

		// read back with rready held low
		runOp("rready hold", {28'h1234567, 4'h5}, makeCtrl(8'h22, 0, 0, 0, 0, 0, `RM_HALF_EVEN),
			{1'b0, 8'h22, 28'h1234568}, 5);

		wait (checkedCount == pushedCount);
		$display("PASS: all tests");
		$finish;
	end

endmodule

`default_nettype wire

// File: sources.f
+incdir+.
dfpPkg.sv
bcdAddN.sv
dfpPack.sv
dfpRound.sv
dfpAxiRegs.sv
dfpRoundTop.sv
tbDfpRound.sv
